// ==== logic/poly_types_pkg.sv ====
//////////////////////////////
// widths are fixed by the 16-bit token format; degree tops out at 15
//////////////////////////////

package poly_types_pkg;

    // token and arithmetic word, products wrap to 16 bits
    typedef logic [15:0] word_t;

    typedef logic [2:0]  slot_t;      // polynomial slot number
    typedef logic [3:0]  coef_idx_t;  // coefficient index within a slot
    typedef logic [4:0]  count_t;     // arg2 of a command

endpackage

// ==== logic/poly_cmd_pkg.sv ====
//////////////////////////////
// command and status word formats; unknown opcodes pass through as raw bytes
//////////////////////////////

package poly_cmd_pkg;

    typedef enum logic [7:0] {
        STP = 8'd0,   // store polynomial
        EVP = 8'd1,   // evaluate at one x
        EVB = 8'd2,   // evaluate on a block of x
        RST = 8'd3    // empty all slots
    } opcode_t;

    typedef enum logic [7:0] {
        st_ok         = 8'd0,
        st_bad_opcode = 8'd1,
        st_bad_arg    = 8'd2,
        st_empty_slot = 8'd3
    } status_t;

    // command word fields
    localparam int op_hi   = 15;
    localparam int op_lo   = 8;
    localparam int slot_hi = 7;   // arg1
    localparam int slot_lo = 5;
    localparam int cnt_hi  = 4;   // arg2, degree or block length
    localparam int cnt_lo  = 0;

    // status word fields
    localparam int stat_op_hi   = 15;  // opcode echo
    localparam int stat_op_lo   = 8;
    localparam int stat_code_hi = 7;
    localparam int stat_code_lo = 0;

endpackage

// ==== logic/poly_ifs.sv ====
//////////////////////////////
// token_if holds req until valid; one token in flight per reader
//////////////////////////////

`timescale 1ns/100ps

// token handshake between a FIFO reader and the controller
interface token_if import poly_types_pkg::*; ();

    logic  req;    // controller wants a token
    logic  ack;    // fifo read issued this cycle
    word_t tok;
    logic  valid;  // tok holds a fresh token

    modport reader (input req, output ack, output tok, output valid);
    modport ctrl   (output req, input ack, input tok, input valid);

endinterface

// coefficient store access
interface coeff_if import poly_types_pkg::*; ();

    slot_t     slot;
    coef_idx_t idx;
    logic      wr;
    word_t     wdata;
    logic      set_degree;   // also marks the slot valid
    coef_idx_t degree_in;
    logic      clear_all;
    word_t     rdata;        // one cycle behind slot and idx
    coef_idx_t degree;
    logic      slot_valid;

    modport ctrl  (output slot, idx, wr, wdata, set_degree, degree_in, clear_all,
                   input rdata, degree, slot_valid);
    modport store (input slot, idx, wr, wdata, set_degree, degree_in, clear_all,
                   output rdata, degree, slot_valid);

endinterface

// ==== logic/token_reader.sv ====
//////////////////////////////
// fifo must present the token one cycle after fifo_rd; latency is 2 cycles
//////////////////////////////

`timescale 1ns/100ps

module token_reader import poly_types_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  word_t  fifo_tok,
    input  word_t  fifo_pop,   // population count
    output logic   fifo_rd,
    token_if.reader port
);

    logic  pending;  // request seen while fifo empty
    logic  busy;     // read issued, token not yet handed over
    logic  capture;  // token on fifo_tok this cycle
    logic  valid_r;
    word_t tok_r;

    assign fifo_rd    = (port.req || pending) && !busy && (fifo_pop != '0);
    assign port.ack   = fifo_rd;
    assign port.tok   = tok_r;
    assign port.valid = valid_r;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pending <= 1'b0;
            busy    <= 1'b0;
            capture <= 1'b0;
            valid_r <= 1'b0;
        end
        else
        begin
            capture <= fifo_rd;
            valid_r <= capture;
            if (fifo_rd)
                busy <= 1'b1;
            else if (valid_r)
                busy <= 1'b0;           // free again after the hand-over
            if (fifo_rd)
                pending <= 1'b0;
            else if (port.req && !busy)
                pending <= 1'b1;        // served once population rises
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
            tok_r <= fifo_tok;
    end

endmodule

// ==== logic/coeff_store.sv ====
//////////////////////////////
// clear_all drops valid flags only; stale coefficients stay in memory
//////////////////////////////

`timescale 1ns/100ps

module coeff_store import poly_types_pkg::*; #(
    parameter int slot_count = 8,    // at most 8
    parameter int max_degree = 15    // at most 15
) (
    input  logic   clk,
    input  logic   rst,
    coeff_if.store mem
);

    word_t                 coef_mem [slot_count][max_degree + 1];
    coef_idx_t             degree_r [slot_count];
    logic [slot_count-1:0] valid_r;
    logic                  slot_ok;
    logic                  idx_ok;

    assign slot_ok = int'(mem.slot) < slot_count;
    assign idx_ok  = int'(mem.idx) <= max_degree;

    // coefficient words, degree per slot, registered read port
    always_ff @(posedge clk)
    begin
        if (mem.wr && slot_ok && idx_ok)
            coef_mem[mem.slot][mem.idx] <= mem.wdata;
        if (mem.set_degree && slot_ok)
            degree_r[mem.slot] <= mem.degree_in;
        if (slot_ok && idx_ok)
            mem.rdata <= coef_mem[mem.slot][mem.idx];   // one cycle behind idx
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            valid_r <= '0;
        else if (mem.clear_all)
            valid_r <= '0;
        else if (mem.set_degree && slot_ok)
            valid_r[mem.slot] <= 1'b1;
    end

    //////////////////////////////
    // lookup by slot, no clock
    assign mem.slot_valid = slot_ok && valid_r[mem.slot];
    assign mem.degree     = slot_ok ? degree_r[mem.slot] : '0;

endmodule

// ==== logic/horner_unit.sv ====
//////////////////////////////
// unsigned only; every product and sum keeps its low 16 bits
//////////////////////////////

`timescale 1ns/100ps

module horner_unit import poly_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  load,   // clear acc before a new x
    input  logic  step,   // apply one coefficient
    input  word_t coef,
    input  word_t x,
    output word_t acc
);

    word_t prod;
    word_t next_acc;

    // acc = acc * x + coef, wrapping
    assign prod     = acc * x;
    assign next_acc = prod + coef;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            acc <= '0;
        end
        else if (load)
        begin
            acc <= '0;
        end
        else if (step)
        begin
            acc <= next_acc;
        end
    end

endmodule

// ==== logic/poly_controller.sv ====
//////////////////////////////
// one command per firing; a rejected command reads no data tokens
//////////////////////////////

`timescale 1ns/100ps

module poly_controller
    import poly_types_pkg::*;
    import poly_cmd_pkg::*;
#(
    parameter int slot_count = 8,
    parameter int max_degree = 15
) (
    input  logic  clk,
    input  logic  rst,
    token_if.ctrl cmd,
    token_if.ctrl dat,
    coeff_if.ctrl mem,
    output logic  h_load,
    output logic  h_step,
    output word_t h_x,
    input  word_t h_acc,
    output word_t result_out,
    output logic  result_wr,
    input  logic  result_full,
    output word_t status_out,
    output logic  status_wr,
    input  logic  status_full
);

    typedef enum logic [3:0] {
        s_idle, s_cmd_wait, s_check, s_stp_req, s_stp_wait, s_x_req,
        s_x_wait, s_prime, s_eval, s_result, s_rst, s_status
    } state_t;

    state_t     state;
    logic [7:0] op_r;       // raw opcode, may be unknown
    slot_t      slot_r;
    count_t     cnt_r;
    count_t     left_r;     // x tokens still to evaluate
    coef_idx_t  idx_r;      // address presented to the store
    coef_idx_t  eval_idx;   // index of the word now on rdata
    word_t      x_r;
    status_t    status_r;
    status_t    chk;
    logic       slot_bad;
    logic       coef_wr;

    assign slot_bad = int'(slot_r) >= slot_count;

    //////////////////////////////
    // argument check
    always_comb
    begin
        chk = st_ok;
        case (op_r)
            STP:
                if (slot_bad || int'(cnt_r) > max_degree)
                    chk = st_bad_arg;
            EVP:
                if (slot_bad)
                    chk = st_bad_arg;
                else if (!mem.slot_valid)
                    chk = st_empty_slot;
            EVB:
                if (slot_bad || cnt_r == '0)
                    chk = st_bad_arg;
                else if (!mem.slot_valid)
                    chk = st_empty_slot;
            RST:
                chk = st_ok;
            default:
                chk = st_bad_opcode;
        endcase
    end

    //////////////////////////////
    // firing sequence
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state    <= s_idle;
            op_r     <= '0;
            slot_r   <= '0;
            cnt_r    <= '0;
            left_r   <= '0;
            idx_r    <= '0;
            eval_idx <= '0;
            x_r      <= '0;
            status_r <= st_ok;
        end
        else
        begin
            case (state)
                s_idle:
                    if (cmd.ack)
                        state <= s_cmd_wait;
                s_cmd_wait:
                    if (cmd.valid)
                    begin
                        op_r   <= cmd.tok[op_hi:op_lo];
                        slot_r <= cmd.tok[slot_hi:slot_lo];
                        cnt_r  <= cmd.tok[cnt_hi:cnt_lo];
                        state  <= s_check;
                    end
                s_check:
                begin
                    status_r <= chk;
                    idx_r    <= '0;
                    left_r   <= cnt_r;
                    if (chk != st_ok)
                        state <= s_status;
                    else if (op_r == STP)
                        state <= s_stp_req;
                    else if (op_r == RST)
                        state <= s_rst;
                    else
                        state <= s_x_req;
                end
                s_stp_req:
                    if (dat.ack)
                        state <= s_stp_wait;
                s_stp_wait:
                    if (dat.valid)
                    begin
                        idx_r <= idx_r + 1'b1;
                        if (idx_r == cnt_r[3:0])
                            state <= s_status;   // last coefficient stored
                        else
                            state <= s_stp_req;
                    end
                s_x_req:
                    if (dat.ack)
                        state <= s_x_wait;
                s_x_wait:
                    if (dat.valid)
                    begin
                        x_r   <= dat.tok;
                        idx_r <= '0;
                        state <= s_prime;
                    end
                s_prime:
                begin
                    eval_idx <= idx_r;
                    idx_r    <= idx_r + 1'b1;
                    state    <= s_eval;
                end
                s_eval:
                begin
                    eval_idx <= idx_r;
                    idx_r    <= idx_r + 1'b1;
                    if (eval_idx == mem.degree)
                        state <= s_result;
                end
                s_result:
                    if (!result_full)
                    begin
                        if (op_r == EVB && left_r != 5'd1)
                        begin
                            left_r <= left_r - 1'b1;
                            state  <= s_x_req;   // next x of the block
                        end
                        else
                            state <= s_status;
                    end
                s_rst:
                    state <= s_status;
                s_status:
                    if (!status_full)
                        state <= s_idle;
                default:
                    state <= s_idle;
            endcase
        end
    end

    //////////////////////////////
    // outputs
    assign cmd.req = (state == s_idle) || (state == s_cmd_wait);
    assign dat.req = state inside {s_stp_req, s_stp_wait, s_x_req, s_x_wait};

    assign coef_wr        = (state == s_stp_wait) && dat.valid;
    assign mem.slot       = slot_r;
    assign mem.idx        = idx_r;
    assign mem.wr         = coef_wr;
    assign mem.wdata      = dat.tok;
    assign mem.set_degree = coef_wr && (idx_r == cnt_r[3:0]);
    assign mem.degree_in  = cnt_r[3:0];
    assign mem.clear_all  = (state == s_rst);

    assign h_load = (state == s_prime);
    assign h_step = (state == s_eval);   // rdata holds coefficient eval_idx
    assign h_x    = x_r;

    assign result_out = h_acc;
    assign result_wr  = (state == s_result) && !result_full;

    always_comb
    begin
        status_out = '0;
        status_out[stat_op_hi:stat_op_lo]     = op_r;
        status_out[stat_code_hi:stat_code_lo] = status_r;
    end
    assign status_wr = (state == s_status) && !status_full;

endmodule

// ==== logic/poly_actor.sv ====
//////////////////////////////
// fifos sit outside; input fifos present a token the cycle after a read
//////////////////////////////

`timescale 1ns/100ps

module poly_actor import poly_types_pkg::*; #(
    parameter int slot_count = 8,    // at most 8
    parameter int max_degree = 15    // at most 15
) (
    input  logic  clk,
    input  logic  rst,
    input  word_t command_in,
    input  word_t command_pop,
    output logic  command_rd,
    input  word_t data_in,
    input  word_t data_pop,
    output logic  data_rd,
    output word_t result_out,
    output logic  result_wr,
    input  logic  result_full,
    output word_t status_out,
    output logic  status_wr,
    input  logic  status_full
);

    token_if cmd_tok ();
    token_if dat_tok ();
    coeff_if mem_bus ();

    logic  h_load;
    logic  h_step;
    word_t h_x;
    word_t h_acc;

    token_reader cmd_reader (
        .clk      (clk),
        .rst      (rst),
        .fifo_tok (command_in),
        .fifo_pop (command_pop),
        .fifo_rd  (command_rd),
        .port     (cmd_tok)
    );

    token_reader dat_reader (
        .clk      (clk),
        .rst      (rst),
        .fifo_tok (data_in),
        .fifo_pop (data_pop),
        .fifo_rd  (data_rd),
        .port     (dat_tok)
    );

    coeff_store #(
        .slot_count (slot_count),
        .max_degree (max_degree)
    ) store (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus)
    );

    horner_unit horner (
        .clk  (clk),
        .rst  (rst),
        .load (h_load),
        .step (h_step),
        .coef (mem_bus.rdata),   // straight from the store read port
        .x    (h_x),
        .acc  (h_acc)
    );

    poly_controller #(
        .slot_count (slot_count),
        .max_degree (max_degree)
    ) ctrl (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd_tok),
        .dat         (dat_tok),
        .mem         (mem_bus),
        .h_load      (h_load),
        .h_step      (h_step),
        .h_x         (h_x),
        .h_acc       (h_acc),
        .result_out  (result_out),
        .result_wr   (result_wr),
        .result_full (result_full),
        .status_out  (status_out),
        .status_wr   (status_wr),
        .status_full (status_full)
    );

endmodule

// ==== tb/poly_actor_tb.sv ====
//////////////////////////////
// fifos are queues; one command in flight at a time with default slot_count and max_degree
//////////////////////////////

`timescale 1ns/100ps

module poly_actor_tb
    import poly_types_pkg::*;
    import poly_cmd_pkg::*;
();

    logic  clk         = 1'b0;
    logic  rst         = 1'b0;
    word_t command_in  = '0;
    word_t command_pop = '0;
    word_t data_in     = '0;
    word_t data_pop    = '0;
    logic  result_full = 1'b0;
    logic  status_full = 1'b0;
    logic  command_rd;
    logic  data_rd;
    word_t result_out;
    logic  result_wr;
    word_t status_out;
    logic  status_wr;

    word_t cmd_q  [$];
    word_t data_q [$];
    word_t res_q  [$];
    word_t stat_q [$];

    int    errors   = 0;
    int    timeouts = 0;
    bit    bp_on    = 1'b0;   // random full flags on the output fifos

    // software copy of the slot memory with the highest power at index 0
    word_t model_coef  [8][16];
    int    model_deg   [8];

    poly_actor poly_actor_i (
        .clk         (clk),
        .rst         (rst),
        .command_in  (command_in),
        .command_pop (command_pop),
        .command_rd  (command_rd),
        .data_in     (data_in),
        .data_pop    (data_pop),
        .data_rd     (data_rd),
        .result_out  (result_out),
        .result_wr   (result_wr),
        .result_full (result_full),
        .status_out  (status_out),
        .status_wr   (status_wr),
        .status_full (status_full)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // input fifo models present a token the cycle after a read
    always @(posedge clk)
    begin
        if (rst)
        begin
            if (command_rd)
            begin
                if (cmd_q.size() == 0)
                begin
                    $display("command FIFO was read while empty");
                    errors++;
                end
                else
                    command_in <= cmd_q.pop_front();
            end
            if (data_rd)
            begin
                if (data_q.size() == 0)
                begin
                    $display("data FIFO was read while empty");
                    errors++;
                end
                else
                    data_in <= data_q.pop_front();
            end
        end
        command_pop <= word_t'(cmd_q.size());
        data_pop    <= word_t'(data_q.size());
    end

    //////////////////////////////
    // output fifo models
    always @(posedge clk)
    begin
        if (rst)
        begin
            if (result_wr)
            begin
                if (result_full)
                begin
                    $display("result written while the result FIFO was full");
                    errors++;
                end
                res_q.push_back(result_out);
            end
            if (status_wr)
            begin
                if (status_full)
                begin
                    $display("status written while the status FIFO was full");
                    errors++;
                end
                stat_q.push_back(status_out);
            end
        end
        if (bp_on)
        begin
            result_full <= ($urandom() & 32'd1) != 0;
            status_full <= ($urandom() & 32'd2) != 0;
        end
        else
        begin
            result_full <= 1'b0;
            status_full <= 1'b0;
        end
    end

    // acc = acc * x + c over the stored words with 16-bit wrap
    function automatic word_t horner_ref(input int slot, input word_t x);
        word_t acc;
        int    i;
        acc = '0;
        for (i = 0; i <= model_deg[slot]; i++)
            acc = acc * x + model_coef[slot][i];
        return acc;
    endfunction

    task automatic push_cmd(input logic [7:0] op, input int slot, input int cnt);
        cmd_q.push_back({op, slot[2:0], cnt[4:0]});
    endtask

    task automatic push_data(input word_t w);
        data_q.push_back(w);
    endtask

    task automatic wait_status(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (stat_q.size() == 0 && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (stat_q.size() == 0)
        begin
            $display("%s: no status word arrived within %0d cycles", name, limit);
            timeouts++;
        end
    endtask

    task automatic check_status(input string name, input logic [7:0] op,
                                input logic [7:0] code);
        word_t exp;
        word_t got;
        exp = {op, code};
        if (stat_q.size() == 0)
        begin
            $display("%s: status word is missing", name);
            errors++;
        end
        else
        begin
            got = stat_q.pop_front();
            if (got != exp)
            begin
                $display("[FAIL] %s: status expected %h actual %h", name, exp, got);
                errors++;
            end
        end
    endtask

    task automatic check_result(input string name, input word_t exp);
        word_t got;
        if (res_q.size() == 0)
        begin
            $display("%s: result word is missing", name);
            errors++;
        end
        else
        begin
            got = res_q.pop_front();
            if (got != exp)
            begin
                $display("[FAIL] %s: result expected %h actual %h", name, exp, got);
                errors++;
            end
        end
    endtask

    task automatic check_no_results(input string name);
        if (res_q.size() != 0)
        begin
            $display("[FAIL] %s: extra results expected 0 actual %0d", name, res_q.size());
            errors++;
            res_q.delete();
        end
    endtask

    task automatic store_poly(input int slot, input int deg, input string name);
        word_t c;
        int    i;
        push_cmd(STP, slot, deg);
        for (i = 0; i <= deg; i++)
        begin
            c = word_t'($urandom());
            model_coef[slot][i] = c;
            push_data(c);
        end
        wait_status(name, 500);
        check_status(name, STP, st_ok);
        check_no_results(name);
        model_deg[slot] = deg;
    endtask

    task automatic eval_point(input int slot, input word_t x, input string name);
        push_cmd(EVP, slot, 0);
        push_data(x);
        wait_status(name, 500);
        check_result(name, horner_ref(slot, x));
        check_no_results(name);
        check_status(name, EVP, st_ok);
    endtask

    // a rejected command leaves its data tokens in the fifo
    task automatic reject_cmd(input string name, input logic [7:0] op, input int slot,
                              input int cnt, input logic [7:0] code, input int n_data);
        int i;
        push_cmd(op, slot, cnt);
        for (i = 0; i < n_data; i++)
            push_data(word_t'($urandom()));
        wait_status(name, 500);
        check_status(name, op, code);
        check_no_results(name);
        if (data_q.size() != n_data)
        begin
            $display("[FAIL] %s: unread data expected %0d actual %0d",
                     name, n_data, data_q.size());
            errors++;
        end
        data_q.delete();   // nothing requests data here
    endtask

    task automatic test_store_eval();
        int i;
        store_poly(1, 3, "stp_deg3");
        store_poly(4, 15, "stp_deg15");
        eval_point(1, 16'h0000, "evp_slot1");
        eval_point(1, 16'h0001, "evp_slot1");
        eval_point(4, 16'hffff, "evp_slot4");
        for (i = 0; i < 3; i++)
        begin
            eval_point(1, word_t'($urandom()), "evp_slot1");
            eval_point(4, word_t'($urandom()), "evp_slot4");
        end
    endtask

    task automatic test_block();
        word_t x;
        word_t exp_q [$];
        int    i;
        push_cmd(EVB, 4, 6);
        for (i = 0; i < 6; i++)
        begin
            x = word_t'($urandom());
            exp_q.push_back(horner_ref(4, x));
            push_data(x);
        end
        wait_status("evb_block", 1000);
        for (i = 0; i < 6; i++)
            check_result("evb_block", exp_q[i]);
        check_no_results("evb_block");
        check_status("evb_block", EVB, st_ok);
    endtask

    task automatic test_errors();
        reject_cmd("bad_opcode", 8'h7e, 2, 1, st_bad_opcode, 0);
        reject_cmd("stp_degree", STP, 2, 20, st_bad_arg, 21);
        reject_cmd("evb_zero", EVB, 1, 0, st_bad_arg, 1);
        reject_cmd("evp_empty", EVP, 6, 0, st_empty_slot, 1);
    endtask

    task automatic test_reset();
        push_cmd(RST, 0, 0);
        wait_status("rst", 500);
        check_status("rst", RST, st_ok);
        check_no_results("rst");
        reject_cmd("evp_after_rst", EVP, 1, 0, st_empty_slot, 1);
        reject_cmd("evb_after_rst", EVB, 4, 2, st_empty_slot, 2);
    endtask

    task automatic test_backpressure();
        word_t x;
        word_t exp_q [$];
        int    i;
        store_poly(1, 5, "bp_store");
        bp_on = 1'b1;
        push_cmd(EVB, 1, 8);
        for (i = 0; i < 8; i++)
        begin
            x = word_t'($urandom());
            exp_q.push_back(horner_ref(1, x));
            push_data(x);
        end
        wait_status("evb_backpressure", 4000);
        bp_on = 1'b0;
        for (i = 0; i < 8; i++)
            check_result("evb_backpressure", exp_q[i]);
        check_no_results("evb_backpressure");   // duplicates land here
        check_status("evb_backpressure", EVB, st_ok);
    endtask

    task automatic test_starved();
        word_t x;
        word_t exp_q [$];
        int    i;
        store_poly(4, 15, "starve_store");
        push_cmd(EVB, 4, 5);
        for (i = 0; i < 5; i++)
        begin
            repeat ($urandom_range(25, 40)) @(negedge clk);   // fifo runs dry
            x = word_t'($urandom());
            exp_q.push_back(horner_ref(4, x));
            push_data(x);
        end
        wait_status("evb_starved", 2000);
        for (i = 0; i < 5; i++)
            check_result("evb_starved", exp_q[i]);
        check_no_results("evb_starved");
        check_status("evb_starved", EVB, st_ok);
    endtask

    //////////////////////////////
    // main sequence touches the queues only on the falling edge
    initial
    begin
        void'($urandom(32'h7ea9));
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        test_store_eval();
        test_block();
        test_errors();
        test_reset();
        test_backpressure();
        test_starved();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
logic/poly_types_pkg.sv
logic/poly_cmd_pkg.sv
logic/poly_ifs.sv
logic/token_reader.sv
logic/coeff_store.sv
logic/horner_unit.sv
logic/poly_controller.sv
logic/poly_actor.sv
tb/poly_actor_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = poly_actor_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
